// File: compile.f
src/sifhPkg.sv
src/histSram.sv
src/histBuilder.sv
src/peakFinder.sv
src/sifhCtrl.sv
src/sifhTop.sv
tb/sifhTb.sv

// File: run.sh
#!/bin/sh
# build and run the histogram engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module sifhTb -o sifhSim

# the simulator exits non-zero on $fatal, the log decides
./obj_dir/sifhSim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0

// File: src/histBuilder.sv
`timescale 1ns/1ps
`default_nettype none

module histBuilder (
    input wire clk,
    input wire res,
    input wire sifhPkg::hitT hit,                     // strobe from the controller
    output logic [sifhPkg::binBits-1:0] rdAddr,       // read issued with the strobe
    input wire [sifhPkg::countWidth-1:0] rdCount,     // count of the stage one bin
    output sifhPkg::memReqT wr                        // write at +2
);
    import sifhPkg::*;

    hitT s1;                               // hit waiting for its read data
    memReqT s2;                            // incremented count, written this cycle
    logic fwd;                             // s2 still owes the bin that s1 read
    logic [countWidth-1:0] base;           // count before the increment
    logic [countWidth-1:0] nextCount;      // count after increment and clamp

    // read goes out in the strobe cycle, the SRAM registers it
    assign rdAddr = hit.bin;

    // back-to-back hits to one bin
    // the SRAM has not seen s2 yet, so take its count instead
    assign fwd = s2.we && (s2.addr == s1.bin);
    assign base = fwd ? s2.count : rdCount;

    assign nextCount = (base == countWidth'(countMax)) ? base : base + 1'b1;   // saturate

    assign wr = s2;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1 <= '0;
            s2 <= '0;
        end else begin
            s1 <= hit;
            s2.addr <= s1.bin;
            s2.we <= s1.valid;     // gated hits pass through as bubbles
            s2.count <= nextCount;
        end
    end

    // every write is at least one hit and never past saturation
    assert property (@(posedge clk) disable iff (!res)
        wr.we |-> (wr.count != '0) && (wr.count <= countWidth'(countMax)));

    // a forwarded bin never loses counts on its next write
    assert property (@(posedge clk) disable iff (!res)
        (s1.valid && fwd) |=> (wr.count >= $past(wr.count)));

endmodule

`default_nettype wire

// File: src/histSram.sv
`timescale 1ns/1ps
`default_nettype none

module histSram (
    input wire clk,
    input wire sifhPkg::memReqT wr,                   // write port
    input wire [sifhPkg::binBits-1:0] rdAddr,         // read port
    output logic [sifhPkg::countWidth-1:0] rdCount    // valid one cycle after rdAddr
);
    import sifhPkg::*;

    logic [countWidth-1:0] mem [binNum];   // contents cleared by the controller
    logic rdHitsWr;                         // same address read and written

    assign rdHitsWr = wr.we && (wr.addr == rdAddr);

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.count;
        end
        // write-first, so a hit two cycles behind its twin sees the new count
        if (rdHitsWr) begin
            rdCount <= wr.count;
        end else begin
            rdCount <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

// File: src/peakFinder.sv
`timescale 1ns/1ps
`default_nettype none

module peakFinder (
    input wire clk,
    input wire res,
    input wire start,                                 // one cycle, first scan cycle
    output logic [sifhPkg::binBits-1:0] rdAddr,
    input wire [sifhPkg::countWidth-1:0] rdCount,
    output logic scanDone,                            // peak is final
    output sifhPkg::peakT peak
);
    import sifhPkg::*;

    logic busy;                    // reads 1..binNum-1 going out
    logic cmpValid;                // rdCount belongs to this scan
    logic [binBits-1:0] cmpBin;    // bin of rdCount
    logic lastRead;

    // rdAddr idles at zero so bin 0 is read in the start cycle
    assign lastRead = busy && (rdAddr == binBits'(binNum - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdAddr <= '0;
            busy <= 1'b0;
            cmpValid <= 1'b0;
            cmpBin <= '0;
            scanDone <= 1'b0;
            peak <= '0;
        end else begin
            scanDone <= 1'b0;
            cmpValid <= start || busy;     // a read went out this cycle
            cmpBin <= rdAddr;
            if (start) begin
                busy <= 1'b1;
                rdAddr <= binBits'(1);
                peak <= '0;                // fresh maximum each scan
            end else if (busy) begin
                if (lastRead) begin
                    busy <= 1'b0;
                    rdAddr <= '0;
                end else begin
                    rdAddr <= rdAddr + 1'b1;
                end
            end
            // strictly greater, so on a tie the lowest bin stays
            if (cmpValid && !start && (rdCount > peak.count)) begin
                peak.bin <= cmpBin;
                peak.count <= rdCount;
            end
            // last data word compared this cycle
            if (cmpValid && !busy && !start) begin
                scanDone <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!res) scanDone |=> !scanDone);

endmodule

`default_nettype wire

// File: src/sifhCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module sifhCtrl (
    input wire clk,
    input wire res,
    input wire tdcValid,                              // plain strobe
    input wire [sifhPkg::tsWidth-1:0] tdcData,
    output logic ready,                               // TDC may send
    output logic done,                                // one cycle, with finePeak
    output sifhPkg::hitT hit,                         // to the builder
    input wire [sifhPkg::binBits-1:0] bldRdAddr,
    input wire sifhPkg::memReqT bldWr,
    input wire [sifhPkg::binBits-1:0] finRdAddr,
    output sifhPkg::memReqT memWr,                    // SRAM write port
    output logic [sifhPkg::binBits-1:0] memRdAddr,    // SRAM read port
    output logic scanStart,
    input wire scanDone,
    input wire sifhPkg::peakT scanPeak,
    output sifhPkg::peakT coarsePeak,
    output sifhPkg::peakT finePeak,
    output sifhPkg::passT pass
);
    import sifhPkg::*;

    typedef enum logic [1:0] {
        sClear,    // zero every bin
        sBuild,    // accept strobes
        sDrain,    // builder pipeline empties
        sScan      // peak search
    } stateT;

    stateT state;
    logic [binBits-1:0] clrCnt;        // bin being zeroed
    logic [hitCntWidth-1:0] hitCnt;    // accepted strobes this pass
    logic drainCnt;
    peakT coarseReg;                   // coarse result, gates the fine pass
    logic accept;
    logic inWindow;
    logic [binBits-1:0] coarseField;
    logic [binBits-1:0] fineField;

    assign accept = tdcValid && ready;
    assign coarseField = tdcData[coarseLsb +: binBits];
    assign fineField = tdcData[fineLsb +: binBits];

    // fine pass keeps only hits under the coarse peak
    assign inWindow = (pass == passCoarse) || (coarseField == coarseReg.bin);
    assign hit.valid = accept && inWindow;      // outside hits still count below
    assign hit.bin = (pass == passCoarse) ? coarseField : fineField;

    // SRAM port owner by phase
    always_comb begin
        memWr = '0;
        memRdAddr = bldRdAddr;
        unique case (state)
            sClear: begin
                memWr.addr = clrCnt;
                memWr.we = 1'b1;       // count stays zero
            end
            sBuild, sDrain: memWr = bldWr;
            sScan: memRdAddr = finRdAddr;
            default: memWr = '0;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= sClear;
            pass <= passCoarse;
            clrCnt <= '0;
            hitCnt <= '0;
            drainCnt <= 1'b0;
            ready <= 1'b0;
            done <= 1'b0;
            scanStart <= 1'b0;
            coarseReg <= '0;
            coarsePeak <= '0;
            finePeak <= '0;
        end else begin
            done <= 1'b0;
            scanStart <= 1'b0;
            unique case (state)
                sClear: begin
                    clrCnt <= clrCnt + 1'b1;   // wraps back to 0
                    if (clrCnt == binBits'(binNum - 1)) begin
                        state <= sBuild;
                        ready <= 1'b1;          // cycle after the last zero write
                        hitCnt <= '0;
                    end
                end
                sBuild: begin
                    if (accept) begin
                        hitCnt <= hitCnt + 1'b1;
                        if (hitCnt == hitCntWidth'(hitsPerPass - 1)) begin
                            ready <= 1'b0;
                            state <= sDrain;
                            drainCnt <= 1'b0;
                        end
                    end
                end
                sDrain: begin
                    drainCnt <= 1'b1;
                    if (drainCnt) begin        // last write landed
                        state <= sScan;
                        scanStart <= 1'b1;
                    end
                end
                sScan: begin
                    if (scanDone) begin
                        state <= sClear;
                        if (pass == passCoarse) begin
                            coarseReg <= scanPeak;
                            pass <= passFine;
                        end else begin
                            // both outputs move together with done
                            coarsePeak <= coarseReg;
                            finePeak <= scanPeak;
                            done <= 1'b1;
                            pass <= passCoarse;
                        end
                    end
                end
                default: state <= sClear;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!res)
        ((state == sClear) || (state == sScan)) |-> !ready);

endmodule

`default_nettype wire

// File: src/sifhPkg.sv
`default_nettype none

package sifhPkg;

    // TDC side
    localparam int tsWidth = 12;          // timestamp width from the TDC

    // histogram geometry
    localparam int binBits = 5;           // coarse and fine bin index
    localparam int binNum = 32;           // bins per histogram, also SRAM depth
    localparam int countWidth = 7;        // one bin count
    localparam int countMax = 127;        // bins stick here

    // pass length
    localparam int hitsPerPass = 256;     // accepted strobes per pass
    localparam int hitCntWidth = $clog2(hitsPerPass);

    // timestamp fields, both binBits wide
    localparam int coarseLsb = 7;         // bits 11..7
    localparam int fineLsb = 2;           // bits 6..2

    // one strobe into the bin incrementer
    typedef struct packed {
        logic [binBits-1:0] bin;
        logic valid;
    } hitT;

    // one SRAM write request
    typedef struct packed {
        logic [binBits-1:0] addr;
        logic we;
        logic [countWidth-1:0] count;
    } memReqT;

    // result of one scan
    typedef struct packed {
        logic [binBits-1:0] bin;
        logic [countWidth-1:0] count;
    } peakT;

    // which histogram is being built
    typedef enum bit {
        passCoarse,
        passFine
    } passT;

endpackage

`default_nettype wire

// File: src/sifhTop.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input wire clk,
    input wire res,
    input wire tdcValid,
    input wire [sifhPkg::tsWidth-1:0] tdcData,
    output logic ready,
    output logic done,
    output sifhPkg::peakT coarsePeak,
    output sifhPkg::peakT finePeak,
    output sifhPkg::passT pass                        // current pass, for the testbench
);
    import sifhPkg::*;

    hitT hit;
    logic [binBits-1:0] bldRdAddr;
    memReqT bldWr;
    logic [binBits-1:0] finRdAddr;
    memReqT memWr;
    logic [binBits-1:0] memRdAddr;
    logic [countWidth-1:0] rdCount;    // shared by builder and finder
    logic scanStart;
    logic scanDone;
    peakT scanPeak;

    sifhCtrl sifhCtrl_i (
        .clk(clk),
        .res(res),
        .tdcValid(tdcValid),
        .tdcData(tdcData),
        .ready(ready),
        .done(done),
        .hit(hit),
        .bldRdAddr(bldRdAddr),
        .bldWr(bldWr),
        .finRdAddr(finRdAddr),
        .memWr(memWr),
        .memRdAddr(memRdAddr),
        .scanStart(scanStart),
        .scanDone(scanDone),
        .scanPeak(scanPeak),
        .coarsePeak(coarsePeak),
        .finePeak(finePeak),
        .pass(pass)
    );

    histBuilder histBuilder_i (
        .clk(clk),
        .res(res),
        .hit(hit),
        .rdAddr(bldRdAddr),
        .rdCount(rdCount),
        .wr(bldWr)
    );

    peakFinder peakFinder_i (
        .clk(clk),
        .res(res),
        .start(scanStart),
        .rdAddr(finRdAddr),
        .rdCount(rdCount),
        .scanDone(scanDone),
        .peak(scanPeak)
    );

    histSram histSram_i (
        .clk(clk),
        .wr(memWr),
        .rdAddr(memRdAddr),
        .rdCount(rdCount)
    );

endmodule

`default_nettype wire

// File: tb/sifhTb.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTb;
    import sifhPkg::*;

    localparam int clkPeriod = 8;
    localparam int resetCycles = 10;
    localparam int numFrames = 5;
    localparam int kNormal = 0;    // biased random stream with gaps
    localparam int kTie = 1;       // four coarse bins in rotation
    localparam int kSat = 2;       // every hit into one bin
    localparam int frameKinds [numFrames] = '{kNormal, kTie, kSat, kNormal, kNormal};
    localparam int watchdogCycles =
        resetCycles + numFrames * 2 * (binNum + hitsPerPass * 4 + binNum + 40);
    localparam logic [binBits-1:0] tieBins [4] = '{5'd20, 5'd6, 5'd11, 5'd25};
    localparam peakT tiePeak = '{bin: 5'd6, count: 7'd64};    // 256 hits over 4 bins
    localparam peakT satCoarse = '{bin: 5'd17, count: countWidth'(countMax)};
    localparam peakT satFine = '{bin: 5'd9, count: countWidth'(countMax)};

    logic clk;
    logic res;
    logic tdcValid;
    logic [tsWidth-1:0] tdcData;
    logic ready;
    logic done;
    peakT coarsePeak;
    peakT finePeak;
    passT pass;

    logic [31:0] seed = 32'hca18;
    int kind;
    logic [binBits-1:0] biasBin;       // favoured coarse bin of a normal frame
    logic [binBits-1:0] fineBias;
    logic [tsWidth-1:0] lastTs;        // for back-to-back repeats
    int relCycles = 0;                 // cycles since reset release
    bit readySeen = 1'b0;
    int doneCnt = 0;

    // reference model
    int hist [2][binNum];              // coarse and fine histograms
    int accCnt = 0;                    // accepted strobes in this pass
    bit fineM = 1'b0;
    passT expPass = passCoarse;        // pass the DUT should be building
    peakT expCoarse = '0;
    peakT expFine = '0;

    sifhTop sifhTop_i (
        .clk(clk),
        .res(res),
        .tdcValid(tdcValid),
        .tdcData(tdcData),
        .ready(ready),
        .done(done),
        .coarsePeak(coarsePeak),
        .finePeak(finePeak),
        .pass(pass)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // highest bin with the lowest index winning a tie
    function automatic peakT peakOf(input int p);
        peakT r;
        r = '0;
        for (int b = 0; b < binNum; b++) begin
            if (hist[p][b] > int'(r.count)) begin
                r.bin = binBits'(b);
                r.count = countWidth'(hist[p][b]);
            end
        end
        return r;
    endfunction

    task automatic abortRun(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic valueMismatch(input string name, input int exp, input int act);
        $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        $display("test failed");
        $fatal(1, "%s mismatch", name);
    endtask

    task automatic peakMismatch(input string name, input peakT exp, input peakT act);
        $display("Fail %s: expected bin %0d count %0d, actual bin %0d count %0d",
            name, exp.bin, exp.count, act.bin, act.count);
        $display("test failed");
        $fatal(1, "%s mismatch", name);
    endtask

    // one strobe per cycle even while ready is low
    task automatic driveStrobe(input int cyc);
        logic [binBits-1:0] cBin;
        logic [binBits-1:0] fBin;
        logic [tsWidth-1:0] ts;
        logic v;
        seed = lcgNext(seed);
        cBin = seed[31:27];
        fBin = seed[26:22];
        v = (seed[13:11] != 3'd0);     // about one gap in eight
        case (kind)
            kTie: begin
                cBin = tieBins[cyc % 4];
                v = 1'b1;              // 64 back-to-back accepts per bin
            end
            kSat: begin
                cBin = satCoarse.bin;
                fBin = satFine.bin;
                v = 1'b1;
            end
            default: begin
                if (pass == passFine) begin
                    if (seed[18:17] != 2'd0) begin
                        cBin = expCoarse.bin;    // mostly inside the window
                    end
                end else if (seed[19]) begin
                    cBin = biasBin;
                end
                if (seed[16]) begin
                    fBin = fineBias;
                end
            end
        endcase
        ts = {cBin, fBin, seed[21:20]};    // coarse 11..7, fine 6..2
        if (kind == kNormal && seed[15:14] == 2'd0) begin
            ts = lastTs;                   // same bin twice in a row
        end
        lastTs = ts;
        tdcValid <= v;
        tdcData <= ts;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        if (res) begin
            relCycles <= relCycles + 1;
        end
        if (ready) begin
            readySeen <= 1'b1;
        end
        if (done) begin
            doneCnt <= doneCnt + 1;
        end
    end

    // counts what the DUT accepts as seen from the TDC side
    always @(posedge clk) begin : model
        logic [binBits-1:0] cf;
        logic [binBits-1:0] ff;
        int p;
        cf = tdcData[coarseLsb +: binBits];
        ff = tdcData[fineLsb +: binBits];
        p = fineM ? 1 : 0;
        if (res && tdcValid && ready) begin
            if (!fineM && hist[0][cf] < countMax) begin
                hist[0][cf]++;
            end else if (fineM && cf == expCoarse.bin && hist[1][ff] < countMax) begin
                hist[1][ff]++;             // hits outside the window only advance accCnt
            end
            accCnt++;
            if (accCnt == hitsPerPass) begin
                if (!fineM) begin
                    expCoarse <= peakOf(0);
                end else begin
                    expFine <= peakOf(1);
                end
                for (int b = 0; b < binNum; b++) begin
                    hist[p][b] = 0;
                end
                accCnt = 0;
                expPass <= fineM ? passCoarse : passFine;
                fineM = !fineM;
            end
        end
    end

    resetQuiet: assert property (@(posedge clk)
        (!res || relCycles < binNum) |-> (!ready && !done))
        else abortRun("ready or done high during reset or the first clear");

    readyRise: assert property (@(posedge clk)
        (res && ready && !readySeen) |-> (relCycles == binNum))
        else valueMismatch("ready rise", binNum, $sampled(relCycles));

    passCheck: assert property (@(posedge clk) disable iff (!res)
        ready |-> (pass == expPass))
        else valueMismatch("pass", expPass, pass);

    coarseCheck: assert property (@(posedge clk) disable iff (!res)
        done |-> (coarsePeak == expCoarse))
        else peakMismatch("coarse peak", expCoarse, coarsePeak);

    fineCheck: assert property (@(posedge clk) disable iff (!res)
        done |-> (finePeak == expFine))
        else peakMismatch("fine peak", expFine, finePeak);

    tieCheck: assert property (@(posedge clk) disable iff (!res)
        (done && kind == kTie) |-> (coarsePeak == tiePeak))
        else peakMismatch("coarse tie", tiePeak, coarsePeak);

    satCoarseCheck: assert property (@(posedge clk) disable iff (!res)
        (done && kind == kSat) |-> (coarsePeak == satCoarse))
        else peakMismatch("saturation coarse", satCoarse, coarsePeak);

    satFineCheck: assert property (@(posedge clk) disable iff (!res)
        (done && kind == kSat) |-> (finePeak == satFine))
        else peakMismatch("saturation fine", satFine, finePeak);

    initial begin : watchdog
        #(watchdogCycles * clkPeriod);
        abortRun("watchdog ran out before all frames finished");
    end

    initial begin : stimulus
        int f;
        int cyc;
        bit frameDone;
        res <= 1'b0;
        tdcValid <= 1'b0;
        tdcData <= '0;
        kind <= kNormal;
        lastTs = '0;
        cyc = 0;
        repeat (resetCycles) @(posedge clk);
        res <= 1'b1;
        for (f = 0; f < numFrames; f++) begin
            kind <= frameKinds[f];     // settles before the next strobe
            seed = lcgNext(seed);
            biasBin = seed[31:27];
            fineBias = seed[26:22];
            frameDone = 1'b0;
            while (!frameDone) begin
                @(posedge clk);
                if (done) begin
                    frameDone = 1'b1;      // done pulsed in the previous cycle
                end
                driveStrobe(cyc);
                cyc++;
            end
        end
        tdcValid <= 1'b0;
        repeat (2) @(posedge clk);
        if (doneCnt == numFrames) begin
            $display("test passed");
            $finish;
        end else begin
            abortRun("fewer done pulses than frames");
        end
    end

endmodule

`default_nettype wire
